// ==== build.f ====
vdc_pkg.sv
vram.sv
vdc_timing.sv
vdc_cpu_port.sv
vdc_vram_arbiter.sv
vdc_bg_fetch.sv
vdc_irq.sv
vdc_top.sv
vdc_chk.sv
tb_vdc.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_vdc -f build.f -o sim_vdc
./obj_dir/sim_vdc > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
  exit 1
fi

// ==== tb_vdc.sv ====
`timescale 1ns/1ps

module tb_vdc;
  import vdc_pkg::*;

  localparam int LINE_CYCLES  = 336;                // (HSW+HDS+HDW+HDE+4) * 8
  localparam int FRAME_LINES  = 263;                // 17 + 240 + 3 + 3
  localparam int FRAME_CYCLES = FRAME_LINES * LINE_CYCLES;
  localparam int WATCHDOG_CYCLES = 14 * FRAME_CYCLES;  // Sync plus two bg frames and irq waits
  localparam logic [11:0] TILE_NUM = 12'h200;       // Tile words at 16'h2000
  localparam int BAT_WORDS    = 64 * 32;            // 64x32 tiles at the MWR reset value
  localparam int MIN_HITS     = 240 * 200;

  logic       clock, reset_N, clock_en;
  logic       cs_n, rd_n, wr_n;
  bus_addr_t  a;
  cpu_data_t  data_in, data_out;
  logic       busy_n, irq_n, hsync_n, vsync_n;
  pixel_t     vd;

  int errors, checks, tests, test_start_errs;
  logic   pix_en;     // Pixel compare window
  pixel_t pix_exp;
  int     pix_hits;
  int     busy_run;   // Current BUSY_n low stretch
  int     busy_reqs;  // Completed BUSY_n low windows

  vdc_top vdc_top_i (
    .clock, .reset_N, .clock_en, .cs_n, .rd_n, .wr_n, .a, .data_in,
    .data_out, .busy_n, .irq_n, .hsync_n, .vsync_n, .vd
  );

  initial begin
    clock = 1'b0;
    forever #(4) clock = ~clock;  // 8 ns period
  end

  initial begin
    #(WATCHDOG_CYCLES * 8);
    $display("Watchdog expired, the tests did not finish in time");
    $display("Simulation FAILED");
    $finish;
  end

  //////////////////////////////
  // Reference and compares
  //////////////////////////////
  // Expected vd for a uniform tile
  // Color 0 always shows palette 0
  function automatic pixel_t ref_pixel(logic [3:0] pal, logic [3:0] color);
    if (color == 4'h0) return 9'h000;
    return {1'b0, pal, color};
  endfunction

  task automatic check_data(string name, cpu_data_t exp, cpu_data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected %02h actual %02h", name, exp, act);
    end
  endtask

  task automatic check_word(string name, vram_data_t exp, vram_data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected %04h actual %04h", name, exp, act);
    end
  endtask

  task automatic check_pixel(string name, pixel_t exp, pixel_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected %03h actual %03h", name, exp, act);
    end
  endtask

  task automatic check_int(string name, int exp, int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("ERR %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  // Every non-overscan sample in the window must be the reference pixel
  always @(negedge clock) begin
    if (pix_en && vd !== OVERSCAN_PIXEL) begin
      check_pixel("bg_pixel", pix_exp, vd);
      if (vd === pix_exp) pix_hits++;
    end
  end

  // One BUSY_n low window per VRAM request, 1 to 8 cycles long
  always @(negedge clock) begin
    if (busy_n === 1'b0) begin
      busy_run++;
    end else if (busy_run != 0) begin
      busy_reqs++;
      if (busy_run > 8) begin
        errors++;
        $display("BUSY_n stayed low for %0d cycles on one VRAM request", busy_run);
      end
      busy_run = 0;
    end
  end

  //////////////////////////////
  // CPU bus
  //////////////////////////////
  task automatic cpu_write(bus_addr_t sel, cpu_data_t d);
    @(posedge clock);
    #1;
    a = sel;
    data_in = d;
    cs_n = 1'b0;
    wr_n = 1'b0;
    repeat (4) @(posedge clock);
    #1;
    wr_n = 1'b1;
    cs_n = 1'b1;
  endtask

  task automatic cpu_read(bus_addr_t sel, output cpu_data_t d);
    @(posedge clock);
    #1;
    a = sel;
    cs_n = 1'b0;
    rd_n = 1'b0;
    repeat (4) @(posedge clock);
    #1;
    d = data_out;              // Before rd_n rises
    rd_n = 1'b1;
    cs_n = 1'b1;
  endtask

  task automatic wait_not_busy();
    int n;
    n = 0;
    while (busy_n !== 1'b1 && n < 20) begin
      @(posedge clock);
      n++;
    end
    if (busy_n !== 1'b1) begin
      errors++;
      $display("BUSY_n stayed low, the VRAM request was never granted");
    end
  endtask

  task automatic write_reg(reg_num_t r, logic [15:0] v);
    wait_not_busy();
    cpu_write(A_STATUS_ADDR, 8'(r));
    cpu_write(A_DATA_LSB, v[7:0]);
    cpu_write(A_DATA_MSB, v[15:8]);  // MARR high byte also fetches
  endtask

  // VWR must already be selected
  task automatic vram_write_word(vram_data_t w);
    wait_not_busy();
    cpu_write(A_DATA_LSB, w[7:0]);
    cpu_write(A_DATA_MSB, w[15:8]);
  endtask

  task automatic vram_read_word(output vram_data_t w);
    cpu_data_t lo, hi;
    wait_not_busy();
    cpu_read(A_DATA_LSB, lo);
    cpu_read(A_DATA_MSB, hi);  // Prefetches the next word
    w = {hi, lo};
  endtask

  task automatic end_test(string name);
    tests++;
    $display("Test %s done, %0d errors", name, errors - test_start_errs);
    test_start_errs = errors;
  endtask

  task automatic wait_vsync_fall();
    while (vsync_n !== 1'b1) @(negedge clock);
    while (vsync_n === 1'b1) @(negedge clock);
  endtask

  task automatic wait_irq(string name);
    int n;
    n = 0;
    while (irq_n === 1'b1 && n < FRAME_CYCLES) begin
      @(negedge clock);
      n++;
    end
    if (irq_n !== 1'b0) begin
      errors++;
      $display("%s: IRQ_n did not go low within one frame", name);
    end
  endtask

  // Uniform BAT and tile followed by one frame of compares
  task automatic bg_frame(logic [3:0] pal, logic [3:0] color, logic fill_bat);
    if (fill_bat) begin
      write_reg(REG_MAWR, 16'h0000);
      cpu_write(A_STATUS_ADDR, 8'(REG_VRR_VWR));
      for (int i = 0; i < BAT_WORDS; i++) vram_write_word({pal, TILE_NUM});
    end
    write_reg(REG_MAWR, {TILE_NUM, 4'h0});
    cpu_write(A_STATUS_ADDR, 8'(REG_VRR_VWR));
    for (int i = 0; i < 8; i++) vram_write_word({{8{color[1]}}, {8{color[0]}}});  // CG0
    for (int i = 0; i < 8; i++) vram_write_word({{8{color[3]}}, {8{color[2]}}});  // CG1
    wait_not_busy();
    pix_exp = ref_pixel(pal, color);
    wait_vsync_fall();
    pix_hits = 0;
    pix_en = 1'b1;
    repeat (FRAME_CYCLES) @(negedge clock);
    pix_en = 1'b0;
    if (pix_hits < MIN_HITS) begin
      errors++;
      $display("Only %0d background pixels matched in one frame", pix_hits);
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////
  initial begin
    vram_addr_t base;
    vram_data_t words [16];
    vram_data_t w, w2;
    cpu_data_t  lo, hi, st;
    logic [3:0] pal, color;
    int         low_cnt;

    void'($urandom(32'h44b1));
    errors = 0;
    checks = 0;
    tests = 0;
    test_start_errs = 0;
    pix_en = 1'b0;
    pix_exp = '0;
    pix_hits = 0;
    busy_run = 0;
    busy_reqs = 0;
    clock_en = 1'b1;
    cs_n = 1'b1;
    rd_n = 1'b1;
    wr_n = 1'b1;
    a = '0;
    data_in = '0;
    reset_N = 1'b0;
    repeat (10) @(posedge clock);
    #1 reset_N = 1'b1;

    // 1. VRAM round trip
    base = 16'h4000 + 16'($urandom % 32'h3000);
    write_reg(REG_MAWR, base);
    cpu_write(A_STATUS_ADDR, 8'(REG_VRR_VWR));
    for (int i = 0; i < 16; i++) begin
      words[i] = 16'($urandom);
      vram_write_word(words[i]);
    end
    write_reg(REG_MARR, base);
    cpu_write(A_STATUS_ADDR, 8'(REG_VRR_VWR));
    for (int i = 0; i < 16; i++) begin
      vram_read_word(w);
      check_word("vram_round_trip", words[i], w);
    end
    // 16 writes, the MARR fetch and 16 read prefetches
    check_int("busy_requests", 33, busy_reqs);
    end_test("vram_round_trip");

    // 2. Only MARR moves on reads (16 reads plus one prefetch)
    wait_not_busy();
    cpu_write(A_STATUS_ADDR, 8'(REG_MARR));
    cpu_read(A_DATA_LSB, lo);
    cpu_read(A_DATA_MSB, hi);
    check_word("marr_increment", base + 16'd17, {hi, lo});
    cpu_write(A_STATUS_ADDR, 8'(REG_MAWR));
    cpu_read(A_DATA_LSB, lo);
    cpu_read(A_DATA_MSB, hi);
    check_word("mawr_unchanged", base + 16'd16, {hi, lo});
    w2 = 16'($urandom);
    cpu_write(A_STATUS_ADDR, 8'(REG_VRR_VWR));
    vram_write_word(w2);
    write_reg(REG_MARR, base + 16'd16);
    cpu_write(A_STATUS_ADDR, 8'(REG_VRR_VWR));
    vram_read_word(w);
    check_word("write_after_reads", w2, w);
    end_test("address_increment");

    // 3. Sync widths
    while (hsync_n !== 1'b1) @(negedge clock);
    while (hsync_n === 1'b1) @(negedge clock);
    low_cnt = 0;
    for (int i = 0; i < LINE_CYCLES; i++) begin
      if (hsync_n === 1'b0) low_cnt++;
      @(negedge clock);
    end
    check_int("hsync_low_cycles", 24, low_cnt);
    check_int("hsync_period", 0, int'(hsync_n));  // Next line starts in sync
    wait_vsync_fall();
    low_cnt = 0;
    for (int i = 0; i < FRAME_CYCLES; i++) begin
      if (vsync_n === 1'b0) low_cnt++;
      @(negedge clock);
    end
    check_int("vsync_low_cycles", 3 * LINE_CYCLES, low_cnt);
    end_test("sync_timing");

    // 4. Background pixels and the same tile with color 0
    pal   = 4'(1 + $urandom % 15);  // Nonzero so the color 0 forcing shows
    color = 4'(1 + $urandom % 15);
    bg_frame(pal, color, 1'b1);
    bg_frame(pal, 4'h0, 1'b0);
    end_test("background_pixels");

    // 5. Vertical-blank interrupt
    write_reg(REG_CR, 16'(1 << CR_VBLANK));
    wait_irq("vblank_irq");
    cpu_read(A_STATUS_ADDR, st);
    check_data("vblank_status", 8'(1 << ST_VBLANK), st);
    @(negedge clock);
    check_int("vblank_irq_cleared", 1, int'(irq_n));
    write_reg(REG_CR, 16'h0000);
    end_test("vblank_irq");

    // 6. Raster interrupt on display row 100
    write_reg(REG_RCR, 16'(RASTER_OFFSET + 100));
    write_reg(REG_CR, 16'(1 << CR_RASTER));
    wait_irq("raster_irq");
    cpu_read(A_STATUS_ADDR, st);
    check_data("raster_status", 8'(1 << ST_RASTER), st);
    write_reg(REG_CR, 16'h0000);
    end_test("raster_irq");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== vdc_chk.sv ====
`timescale 1ns/1ps

module vdc_chk (
  input logic                 clock,
  input logic                 reset_N,
  input logic                 clock_en,
  input vdc_pkg::char_cycle_t char_cycle,
  input vdc_pkg::h_state_t    h_state,
  input logic                 mem_we,
  input logic                 cpu_grant,
  input logic                 cpu_req,
  input logic                 ack,
  input logic                 irq_n,
  input logic                 hsync_n
);
  import vdc_pkg::*;

  // Writes land only on even dots
  a_we_slot: assert property (@(posedge clock) disable iff (!reset_N)
    mem_we |-> !char_cycle[0]) else $error("VRAM write outside a CPU slot");

  a_grant_req: assert property (@(posedge clock) disable iff (!reset_N)
    cpu_grant |-> cpu_req) else $error("Grant without a request");

  // Status read drops the interrupt line
  a_ack_irq: assert property (@(posedge clock) disable iff (!reset_N)
    (ack && clock_en) |=> irq_n) else $error("IRQ_n low after ack");

  a_hsync: assert property (@(posedge clock) disable iff (!reset_N)
    !hsync_n |-> (h_state == H_SYNC)) else $error("HSYNC_n low outside H_SYNC");

endmodule

bind vdc_top vdc_chk chk_i (.*);

// ==== vdc_top.sv ====
`timescale 1ns/1ps

module vdc_top (
  input  logic               clock,
  input  logic               reset_N,
  input  logic               clock_en,
  input  logic               cs_n,
  input  logic               rd_n,
  input  logic               wr_n,
  input  vdc_pkg::bus_addr_t a,
  input  vdc_pkg::cpu_data_t data_in,
  output vdc_pkg::cpu_data_t data_out,
  output logic               busy_n,
  output logic               irq_n,
  output logic               hsync_n,
  output logic               vsync_n,
  output vdc_pkg::pixel_t    vd
);
  import vdc_pkg::*;

  ////////////////////////////////
  // Timing fan-out
  ////////////////////////////////
  char_cycle_t char_cycle;
  h_state_t    h_state;
  v_state_t    v_state;
  count_t      h_cnt, v_cnt;
  logic        end_of_line, bg_fetch_active, in_display;

  // CPU side registers and request
  logic        cpu_req, cpu_write, cpu_grant, ack;
  vram_addr_t  cpu_addr, bg_addr, mem_addr;
  vram_data_t  cpu_wdata, mem_rdata;
  logic        mem_we;
  logic [12:0] cr;
  count_t      rcr, bxr, byr;
  cpu_data_t   mwr, status;

  vdc_timing timing_i (
    .clock, .reset_N, .clock_en, .char_cycle, .h_state, .v_state, .h_cnt, .v_cnt,
    .end_of_line, .bg_fetch_active, .in_display, .hsync_n, .vsync_n
  );

  vdc_cpu_port cpu_port_i (
    .clock, .reset_N, .clock_en, .cs_n, .rd_n, .wr_n, .a, .data_in, .cpu_grant,
    .mem_rdata, .status, .data_out, .busy_n, .cpu_req, .cpu_write, .cpu_addr,
    .cpu_wdata, .ack, .cr, .rcr, .bxr, .byr, .mwr
  );

  vdc_vram_arbiter arbiter_i (
    .char_cycle, .bg_fetch_active, .bg_addr, .cpu_req, .cpu_write, .cpu_addr,
    .cpu_grant, .mem_addr, .mem_we
  );

  vdc_bg_fetch bg_fetch_i (
    .clock, .reset_N, .clock_en, .char_cycle, .h_state, .v_state, .h_cnt,
    .bg_fetch_active, .in_display, .bxr, .byr, .mwr, .mem_rdata, .bg_addr, .vd
  );

  vdc_irq irq_i (
    .clock, .reset_N, .clock_en, .v_state, .v_cnt, .end_of_line, .cr, .rcr, .ack,
    .status, .irq_n
  );

  vram vram_i (
    .clock, .addr(mem_addr), .we(mem_we), .wdata(cpu_wdata), .rdata(mem_rdata)
  );

endmodule

// ==== vdc_irq.sv ====
`timescale 1ns/1ps

module vdc_irq (
  input  logic               clock,
  input  logic               reset_N,
  input  logic               clock_en,
  input  vdc_pkg::v_state_t  v_state,
  input  vdc_pkg::count_t    v_cnt,
  input  logic               end_of_line,
  input  logic [12:0]        cr,
  input  vdc_pkg::count_t    rcr,
  input  logic               ack,
  output vdc_pkg::cpu_data_t status,
  output logic               irq_n
);
  import vdc_pkg::*;

  v_state_t prev_v_state;
  count_t   cur_row;     // Display row, 0 at top
  logic     vblank_hit, raster_hit;

  // Falling out of the display area
  assign vblank_hit = cr[CR_VBLANK] && (prev_v_state == V_DISP) && (v_state != V_DISP);

  // Checked at line end, from the last blank line through the display
  assign raster_hit = end_of_line && cr[CR_RASTER] && (rcr >= RASTER_OFFSET) &&
                      ((v_state == V_WAIT && v_cnt == '0) || v_state == V_DISP) &&
                      (cur_row + 10'd1 == rcr - RASTER_OFFSET);

  always_ff @(posedge clock, negedge reset_N) begin
    if (~reset_N) begin
      prev_v_state <= V_SYNC;
      cur_row      <= '0;
      status       <= '0;
      irq_n        <= 1'b1;
    end else if (clock_en) begin
      prev_v_state <= v_state;
      if (v_state == V_WAIT) cur_row <= '0;
      else if (end_of_line && v_state == V_DISP) cur_row <= cur_row + 10'd1;
      if (ack) begin               // Status read wins over a fresh event
        status <= '0;
        irq_n  <= 1'b1;
      end else begin
        if (vblank_hit) begin
          status[ST_VBLANK] <= 1'b1;
          irq_n             <= 1'b0;
        end
        if (raster_hit) begin
          status[ST_RASTER] <= 1'b1;
          irq_n             <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== vdc_bg_fetch.sv ====
`timescale 1ns/1ps

module vdc_bg_fetch (
  input  logic                 clock,
  input  logic                 reset_N,
  input  logic                 clock_en,
  input  vdc_pkg::char_cycle_t char_cycle,
  input  vdc_pkg::h_state_t    h_state,
  input  vdc_pkg::v_state_t    v_state,
  input  vdc_pkg::count_t      h_cnt,
  input  logic                 bg_fetch_active,
  input  logic                 in_display,
  input  vdc_pkg::count_t      bxr,
  input  vdc_pkg::count_t      byr,
  input  vdc_pkg::cpu_data_t   mwr,
  input  vdc_pkg::vram_data_t  mem_rdata,
  output vdc_pkg::vram_addr_t  bg_addr,
  output vdc_pkg::pixel_t      vd
);
  import vdc_pkg::*;

  count_t      x_start, y_start;   // Scroll, latched once per line
  count_t      cur_row, row_sum;   // Row in pixels
  logic [6:0]  cur_col, x_mask;    // Column in tiles
  logic [2:0]  y_shift;            // log2 of BAT width
  count_t      y_mask;
  vram_addr_t  bat_ptr, tile_ptr;
  logic [1:0]  wr_ptr, rd_ptr;
  logic [2:0]  cycle_adj, px_bit;
  logic [3:0]  tile_pix;
  logic [3:0]  pipe_pal [BG_PIPE_LEN];
  vram_data_t  pipe_cg0 [BG_PIPE_LEN];
  vram_data_t  pipe_cg1 [BG_PIPE_LEN];

  ////////////////////////////////
  // BAT addressing
  ////////////////////////////////
  // MWR[5:4] width 32/64/128 tiles, MWR[6] height 32/64 tiles
  assign y_shift = mwr[5] ? 3'd7 : (mwr[4] ? 3'd6 : 3'd5);
  assign x_mask  = mwr[5] ? 7'h7f : (mwr[4] ? 7'h3f : 7'h1f);
  assign y_mask  = mwr[6] ? 10'h1ff : 10'h0ff;
  assign row_sum = (cur_row + y_start) & y_mask;
  assign bat_ptr = vram_addr_t'(cur_col) + (vram_addr_t'(row_sum[9:3]) << y_shift);

  always_comb begin
    case (char_cycle)
      3'd5:    bg_addr = tile_ptr;               // CG0, planes 0/1
      3'd7:    bg_addr = tile_ptr + CG1_OFFSET;  // CG1, planes 2/3
      default: bg_addr = bat_ptr;
    endcase
  end

  always_ff @(posedge clock, negedge reset_N) begin
    if (~reset_N) begin
      x_start <= '0; y_start <= '0;
      cur_row <= '0; cur_col <= '0;
      wr_ptr  <= '0; rd_ptr  <= '0;
    end else if (clock_en) begin
      if (h_state == H_SYNC && char_cycle == 3'd6) begin
        x_start <= bxr;
        y_start <= byr;
      end
      if (v_state == V_WAIT) cur_row <= '0;  // Frame restarts at row 0
      else if (h_state == H_DISP && h_cnt == '0 && char_cycle == 3'd7) cur_row <= cur_row + 10'd1;
      if (h_state == H_SYNC && h_cnt == '0 && char_cycle == 3'd7) begin
        cur_col <= x_start[9:3];
      end else if (bg_fetch_active && char_cycle == 3'd7) begin
        cur_col <= (cur_col + 7'd1) & x_mask;  // Wrap on screen width
      end
      // Ring write side, one slot per fetched tile
      if (!bg_fetch_active) wr_ptr <= '0;
      else if (char_cycle == 3'd7) wr_ptr <= (wr_ptr == 2'(BG_PIPE_LEN - 1)) ? 2'd0 : wr_ptr + 2'd1;
      // Read side trails by two tiles, shifted by fine scroll
      if (!in_display) rd_ptr <= '0;
      else if (cycle_adj == 3'd7) rd_ptr <= (rd_ptr == 2'(BG_PIPE_LEN - 1)) ? 2'd0 : rd_ptr + 2'd1;
    end
  end

  ////////////////////////////////
  // Tile line pipeline
  ////////////////////////////////
  always_ff @(posedge clock) begin
    if (clock_en && bg_fetch_active) begin
      case (char_cycle)
        3'd1: begin
          pipe_pal[wr_ptr] <= mem_rdata[15:12];  // BAT palette
          tile_ptr <= {mem_rdata[11:0], 4'h0} + vram_addr_t'(row_sum[2:0]);
        end
        3'd5: pipe_cg0[wr_ptr] <= mem_rdata;
        3'd7: pipe_cg1[wr_ptr] <= mem_rdata;
        default: ;
      endcase
    end
  end

  assign cycle_adj = char_cycle + x_start[2:0];
  assign px_bit    = 3'd7 - cycle_adj;  // Leftmost dot is the MSB of each byte
  assign tile_pix  = {pipe_cg1[rd_ptr][{1'b1, px_bit}], pipe_cg1[rd_ptr][{1'b0, px_bit}],
                      pipe_cg0[rd_ptr][{1'b1, px_bit}], pipe_cg0[rd_ptr][{1'b0, px_bit}]};

  // Color 0 is transparent, shown as palette 0
  assign vd = !in_display ? OVERSCAN_PIXEL :
              {1'b0, (tile_pix == 4'h0) ? 4'h0 : pipe_pal[rd_ptr], tile_pix};

endmodule

// ==== vdc_vram_arbiter.sv ====
`timescale 1ns/1ps

module vdc_vram_arbiter (
  input  vdc_pkg::char_cycle_t char_cycle,
  input  logic                 bg_fetch_active,
  input  vdc_pkg::vram_addr_t  bg_addr,
  input  logic                 cpu_req,
  input  logic                 cpu_write,
  input  vdc_pkg::vram_addr_t  cpu_addr,
  output logic                 cpu_grant,
  output vdc_pkg::vram_addr_t  mem_addr,
  output logic                 mem_we
);

  logic bg_slot;   // Fetcher owns this dot
  logic cpu_slot;  // CPU may use this dot

  // BAT at 1, CG0 at 5, CG1 at 7 while the fetcher runs
  assign bg_slot = bg_fetch_active &&
                   (char_cycle == 3'd1 || char_cycle == 3'd5 || char_cycle == 3'd7);

  // CPU always lives on even dots
  assign cpu_slot = ~char_cycle[0];

  assign cpu_grant = cpu_req && cpu_slot;           // Single dot, no handshake
  assign mem_we    = cpu_grant && cpu_write;
  assign mem_addr  = bg_slot ? bg_addr : cpu_addr;

endmodule

// ==== vdc_cpu_port.sv ====
`timescale 1ns/1ps

module vdc_cpu_port (
  input  logic                clock,
  input  logic                reset_N,
  input  logic                clock_en,
  input  logic                cs_n,
  input  logic                rd_n,
  input  logic                wr_n,
  input  vdc_pkg::bus_addr_t  a,
  input  vdc_pkg::cpu_data_t  data_in,
  input  logic                cpu_grant,
  input  vdc_pkg::vram_data_t mem_rdata,
  input  vdc_pkg::cpu_data_t  status,
  output vdc_pkg::cpu_data_t  data_out,
  output logic                busy_n,
  output logic                cpu_req,
  output logic                cpu_write,
  output vdc_pkg::vram_addr_t cpu_addr,
  output vdc_pkg::vram_data_t cpu_wdata,
  output logic                ack,
  output logic [12:0]         cr,
  output vdc_pkg::count_t     rcr,
  output vdc_pkg::count_t     bxr,
  output vdc_pkg::count_t     byr,
  output vdc_pkg::cpu_data_t  mwr
);
  import vdc_pkg::*;

  logic       rd, wr, prev_rd, prev_wr;
  logic       rd_rise, wr_rise;
  logic       read_start, write_start;
  reg_num_t   regnum;        // Selected by a write at A 0
  vram_addr_t mawr, marr;
  vram_data_t rbuf;          // Last word fetched for the CPU
  vram_data_t rd_word;
  mem_state_t mem_state, mem_next;

  ////////////////////////////////
  // Strobe edges
  ////////////////////////////////
  assign rd = ~rd_n & ~cs_n;
  assign wr = ~wr_n & ~cs_n;

  always_ff @(posedge clock, negedge reset_N) begin
    if (~reset_N) begin
      prev_rd <= 1'b0;
      prev_wr <= 1'b0;
    end else if (clock_en) begin
      prev_rd <= rd;
      prev_wr <= wr;
    end
  end

  assign rd_rise = rd & ~prev_rd;
  assign wr_rise = wr & ~prev_wr;
  assign ack     = rd_rise && (a == A_STATUS_ADDR);  // Status read clears IRQ

  // Only the high byte kicks off a VRAM cycle
  assign write_start = wr_rise && (a == A_DATA_MSB) && (regnum == REG_VRR_VWR);
  assign read_start  = (a == A_DATA_MSB) &&
                       ((wr_rise && regnum == REG_MARR) || (rd_rise && regnum == REG_VRR_VWR));

  ////////////////////////////////
  // Register file
  ////////////////////////////////
  always_ff @(posedge clock, negedge reset_N) begin
    if (~reset_N) begin
      regnum <= '0; mawr <= '0; marr <= '0; rbuf <= '0; cpu_wdata <= '0;
      cr <= '0; rcr <= '0; bxr <= '0; byr <= '0;
      mwr <= MWR_RESET;
    end else if (clock_en) begin
      // Post-increment of the address that was used
      if (cpu_grant && mem_state == MEM_WRITE) mawr <= mawr + 16'd1;
      if (cpu_grant && mem_state == MEM_READ) begin
        marr <= marr + 16'd1;
        rbuf <= mem_rdata;
      end
      if (wr_rise) begin
        case (a)
          A_STATUS_ADDR: regnum <= data_in[4:0];
          A_DATA_LSB: begin
            case (regnum)
              REG_MAWR:    mawr[7:0]      <= data_in;
              REG_MARR:    marr[7:0]      <= data_in;
              REG_VRR_VWR: cpu_wdata[7:0] <= data_in;
              REG_CR:      cr[7:0]        <= data_in;
              REG_RCR:     rcr[7:0]       <= data_in;
              REG_BXR:     bxr[7:0]       <= data_in;
              REG_BYR:     byr[7:0]       <= data_in;
              REG_MWR:     mwr            <= data_in;
              default: ;
            endcase
          end
          A_DATA_MSB: begin
            case (regnum)
              REG_MAWR:    mawr[15:8]      <= data_in;
              REG_MARR:    marr[15:8]      <= data_in;  // Also starts a fetch
              REG_VRR_VWR: cpu_wdata[15:8] <= data_in;  // Also starts a write
              REG_CR:      cr[12:8]        <= data_in[4:0];
              REG_RCR:     rcr[9:8]        <= data_in[1:0];
              REG_BXR:     bxr[9:8]        <= data_in[1:0];
              REG_BYR:     byr[9:8]        <= data_in[1:0];
              default: ;                               // MWR is one byte
            endcase
          end
          default: ;
        endcase
      end
    end
  end

  ////////////////////////////////
  // VRAM request FSM
  ////////////////////////////////
  always_comb begin
    mem_next = mem_state;
    if (mem_state == MEM_IDLE) begin
      if (read_start)       mem_next = MEM_READ;
      else if (write_start) mem_next = MEM_WRITE;
    end else if (cpu_grant) begin
      mem_next = MEM_IDLE;  // Held until the arbiter gives a slot
    end
  end

  always_ff @(posedge clock, negedge reset_N) begin
    if (~reset_N) mem_state <= MEM_IDLE;
    else if (clock_en) mem_state <= mem_next;
  end

  assign cpu_req   = (mem_state != MEM_IDLE);
  assign cpu_write = (mem_state == MEM_WRITE);
  assign cpu_addr  = cpu_write ? mawr : marr;
  assign busy_n    = ~cpu_req;  // Low until grant

  // Address registers read back, everything else gives the read buffer
  always_comb begin
    case (regnum)
      REG_MAWR: rd_word = mawr;
      REG_MARR: rd_word = marr;
      default:  rd_word = rbuf;
    endcase
  end

  always_ff @(posedge clock, negedge reset_N) begin
    if (~reset_N) begin
      data_out <= '0;
    end else if (clock_en && rd_rise) begin
      case (a)
        A_STATUS_ADDR: data_out <= status;
        A_DATA_LSB:    data_out <= rd_word[7:0];
        A_DATA_MSB:    data_out <= rd_word[15:8];
        default:       data_out <= '0;  // A 1 reads as zero
      endcase
    end
  end

endmodule

// ==== vdc_timing.sv ====
`timescale 1ns/1ps

module vdc_timing (
  input  logic                 clock,
  input  logic                 reset_N,
  input  logic                 clock_en,
  output vdc_pkg::char_cycle_t char_cycle,
  output vdc_pkg::h_state_t    h_state,
  output vdc_pkg::v_state_t    v_state,
  output vdc_pkg::count_t      h_cnt,
  output vdc_pkg::count_t      v_cnt,
  output logic                 end_of_line,
  output logic                 bg_fetch_active,
  output logic                 in_display,
  output logic                 hsync_n,
  output logic                 vsync_n
);
  import vdc_pkg::*;

  ////////////////////////////////
  // Horizontal
  ////////////////////////////////
  // Each phase counts down from its width, steps on the last dot of a char
  always_ff @(posedge clock, negedge reset_N) begin
    if (~reset_N) begin
      char_cycle <= '0;
      h_cnt      <= HSW;
      h_state    <= H_SYNC;  // Line starts in sync
    end else if (clock_en) begin
      char_cycle <= char_cycle + 3'd1;
      if (char_cycle == 3'd7) begin
        h_cnt <= h_cnt - 10'd1;
        if (h_cnt == '0) begin
          case (h_state)
            H_SYNC: begin h_cnt <= HDS; h_state <= H_WAIT; end
            H_WAIT: begin h_cnt <= HDW; h_state <= H_DISP; end
            H_DISP: begin h_cnt <= HDE; h_state <= H_END;  end
            default: begin h_cnt <= HSW; h_state <= H_SYNC; end
          endcase
        end
      end
    end
  end

  assign end_of_line = (char_cycle == 3'd7) && (h_state == H_END) && (h_cnt == '0);

  ////////////////////////////////
  // Vertical
  ////////////////////////////////
  always_ff @(posedge clock, negedge reset_N) begin
    if (~reset_N) begin
      v_cnt   <= VDS + 10'd1;
      v_state <= V_WAIT;
    end else if (clock_en && end_of_line) begin
      v_cnt <= v_cnt - 10'd1;  // One step per line
      if (v_cnt == '0) begin
        case (v_state)
          V_WAIT: begin
            v_cnt   <= VDW;          // VDW+1 display lines
            v_state <= V_DISP;
          end
          V_DISP: begin
            v_cnt   <= VDE - 10'd1;  // VDE lines of bottom blank
            v_state <= V_END;
          end
          V_END: begin
            v_cnt   <= VSW;
            v_state <= V_SYNC;
          end
          default: begin
            v_cnt   <= VDS + 10'd1;  // Top blank, VDS+2 lines
            v_state <= V_WAIT;
          end
        endcase
      end
    end
  end

  // Two tiles of prefetch at the tail of H_WAIT fill the pipe before display
  assign bg_fetch_active = (v_state == V_DISP) &&
                           ((h_state == H_DISP) || (h_state == H_WAIT && h_cnt < 10'd2));
  assign in_display      = (h_state == H_DISP) && (v_state == V_DISP);

  assign hsync_n = (h_state != H_SYNC);
  assign vsync_n = (v_state != V_SYNC);  // No separate frame counter

endmodule

// ==== vram.sv ====
`timescale 1ns/1ps

module vram (
  input  logic                clock,
  input  vdc_pkg::vram_addr_t addr,
  input  logic                we,
  input  vdc_pkg::vram_data_t wdata,
  output vdc_pkg::vram_data_t rdata
);
  import vdc_pkg::*;

  vram_data_t mem [0:65535];  // 64K words

  // Read is combinational, data valid in the same slot
  assign rdata = mem[addr];

  always_ff @(posedge clock) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

endmodule

// ==== vdc_pkg.sv ====
package vdc_pkg;

  ////////////////////////////////
  // Widths with a meaning
  ////////////////////////////////
  typedef logic [15:0] vram_addr_t;   // VRAM word address
  typedef logic [15:0] vram_data_t;   // VRAM data word
  typedef logic [7:0]  cpu_data_t;    // CPU bus byte
  typedef logic [4:0]  reg_num_t;     // Latched register number
  typedef logic [1:0]  bus_addr_t;    // A pins
  typedef logic [2:0]  char_cycle_t;  // Dot inside an 8-dot character
  typedef logic [9:0]  count_t;       // Position counters
  typedef logic [8:0]  pixel_t;       // {sprite sel, palette, color}

  // Horizontal and vertical phases
  typedef enum logic [1:0] {H_SYNC, H_WAIT, H_DISP, H_END} h_state_t;
  typedef enum logic [1:0] {V_SYNC, V_WAIT, V_DISP, V_END} v_state_t;

  // CPU side VRAM access FSM
  typedef enum logic [1:0] {MEM_IDLE, MEM_READ, MEM_WRITE} mem_state_t;

  ////////////////////////////////
  // CPU bus
  ////////////////////////////////
  localparam bus_addr_t A_STATUS_ADDR = 2'd0;  // Status read, register number write
  localparam bus_addr_t A_DATA_LSB    = 2'd2;
  localparam bus_addr_t A_DATA_MSB    = 2'd3;

  localparam reg_num_t REG_MAWR    = 5'h00;  // Write address
  localparam reg_num_t REG_MARR    = 5'h01;  // Read address
  localparam reg_num_t REG_VRR_VWR = 5'h02;  // VRAM data port
  localparam reg_num_t REG_CR      = 5'h05;
  localparam reg_num_t REG_RCR     = 5'h06;
  localparam reg_num_t REG_BXR     = 5'h07;
  localparam reg_num_t REG_BYR     = 5'h08;
  localparam reg_num_t REG_MWR     = 5'h09;

  ////////////////////////////////
  // Fixed timing, all minus one
  ////////////////////////////////
  localparam count_t HSW = 10'd2;    // HSYNC width
  localparam count_t HDS = 10'd2;    // Start of display
  localparam count_t HDW = 10'd31;   // Display width in tiles
  localparam count_t HDE = 10'd3;    // End period
  localparam count_t VSW = 10'd2;    // VSYNC width
  localparam count_t VDS = 10'd15;   // Top blank, minus two
  localparam count_t VDW = 10'd239;  // Display height in lines
  localparam count_t VDE = 10'd3;    // Bottom blank, not minus one

  localparam cpu_data_t  MWR_RESET     = 8'h10;   // 64 tile wide screen
  localparam count_t     RASTER_OFFSET = 10'd64;  // RCR value of display row 0
  localparam vram_addr_t CG1_OFFSET    = 16'd8;   // Planes 2/3 sit 8 words up
  localparam int         BG_PIPE_LEN   = 3;       // Tiles in flight

  // CR enables and status flags
  localparam int CR_RASTER = 2;
  localparam int CR_VBLANK = 3;
  localparam int ST_RASTER = 2;
  localparam int ST_VBLANK = 5;

  localparam pixel_t OVERSCAN_PIXEL = 9'h100;  // Sprite palette 0, color 0

endpackage
